// ==== common/emult_pkg.sv ====
package emult_pkg;

	// Lanes per transaction and the two-lane DSP blocks that carry them.
	localparam int NUM_LANES = 16;
	localparam int NUM_PAIRS = NUM_LANES / 2;

	// Operand format.
	localparam int DATA_WIDTH = 18; // Operand and result width.
	localparam int FRAC_BITS = 10; // Fraction bits of an operand.

	// A full 36-bit signed product plus one extra sign bit.
	localparam int PROD_WIDTH = 2 * DATA_WIDTH + 1;

	// Product bit just below the cut, used to round to nearest.
	localparam int ROUND_BIT = FRAC_BITS - 1;

	// One lane value, signed with FRAC_BITS fraction bits.
	typedef logic signed [DATA_WIDTH-1:0] fixed_t;

	// Full-precision product, which has 2*FRAC_BITS fraction bits.
	typedef logic signed [PROD_WIDTH-1:0] product_t;

	// All lanes of a transaction packed into one vector; lane 0 is in the low bits.
	typedef fixed_t [NUM_LANES-1:0] lane_vec_t;

endpackage

// ==== hdl/operand_capture.sv ====
module operand_capture import emult_pkg::*; (
	input logic clk,
	input logic reset,
	input logic i_enable,
	input logic i_valid,
	input lane_vec_t i_a,
	input lane_vec_t i_b,
	output lane_vec_t o_a,
	output lane_vec_t o_b,
	output logic o_valid
);

	lane_vec_t a_q;
	lane_vec_t b_q;
	logic valid_q;

	// The whole lane width is registered here once, so the multiplier
	// pairs see only local flops and not the external input timing.
	always_ff @(posedge clk) begin
		if (reset) begin
			a_q <= '0;
			b_q <= '0;
			valid_q <= 1'b0;
		end else if (i_enable) begin
			a_q <= i_a;
			b_q <= i_b;
			valid_q <= i_valid; // Bubbles travel as valid low.
		end
	end

	assign o_a = a_q;
	assign o_b = b_q;
	assign o_valid = valid_q;

endmodule

// ==== mult/dsp_mult_pair.sv ====
module dsp_mult_pair import emult_pkg::*; (
	input logic clk,
	input logic reset,
	input logic i_enable,
	input logic i_valid,
	input fixed_t i_ax,
	input fixed_t i_ay,
	input fixed_t i_bx,
	input fixed_t i_by,
	output product_t o_res_a,
	output product_t o_res_b,
	output logic o_valid
);

	// Input register of the DSP block.
	fixed_t ax_q;
	fixed_t ay_q;
	fixed_t bx_q;
	fixed_t by_q;

	// Product register of the DSP block.
	product_t res_a_q;
	product_t res_b_q;

	// Valid follows the two data registers one for one.
	logic [1:0] valid_sr;

	always_ff @(posedge clk) begin
		if (reset) begin
			ax_q <= '0;
			ay_q <= '0;
			bx_q <= '0;
			by_q <= '0;
		end else if (i_enable) begin
			ax_q <= i_ax;
			ay_q <= i_ay;
			bx_q <= i_bx;
			by_q <= i_by;
		end
	end

	// Both factors are signed, so the product is sign-extended to PROD_WIDTH.
	always_ff @(posedge clk) begin
		if (reset) begin
			res_a_q <= '0;
			res_b_q <= '0;
		end else if (i_enable) begin
			res_a_q <= ax_q * ay_q;
			res_b_q <= bx_q * by_q;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_sr <= 2'b00;
		end else if (i_enable) begin
			valid_sr <= {valid_sr[0], i_valid};
		end
	end

	assign o_res_a = res_a_q;
	assign o_res_b = res_b_q;
	assign o_valid = valid_sr[1];

endmodule

// ==== round/fixed_round_unit.sv ====
module fixed_round_unit import emult_pkg::*; (
	input logic clk,
	input logic reset,
	input logic i_enable,
	input logic i_valid,
	input product_t i_prod,
	output fixed_t o_result,
	output logic o_valid
);

	product_t shifted; // Product back in the operand scale, truncated.
	product_t rounded; // Floor or ceiling after the round decision.

	// First register: both candidates and the decision bit.
	product_t floor_q;
	product_t ceil_q;
	logic round_bit_q;
	logic stage1_valid;

	// Second register: the narrowed result.
	fixed_t result_q;
	logic stage2_valid;

	// Arithmetic shift, since product_t is signed.
	assign shifted = i_prod >>> FRAC_BITS;

	always_ff @(posedge clk) begin
		if (reset) begin
			floor_q <= '0;
			ceil_q <= '0;
			round_bit_q <= 1'b0;
			stage1_valid <= 1'b0;
		end else if (i_enable) begin
			floor_q <= shifted;
			ceil_q <= shifted + 1'b1;
			round_bit_q <= i_prod[ROUND_BIT]; // Half or more of an LSB rounds up.
			stage1_valid <= i_valid;
		end
	end

	// Ties go toward positive infinity, negative values included.
	assign rounded = round_bit_q ? ceil_q : floor_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			result_q <= '0;
			stage2_valid <= 1'b0;
		end else if (i_enable) begin
			result_q <= rounded[DATA_WIDTH-1:0]; // Wraps on overflow.
			stage2_valid <= stage1_valid;
		end
	end

	assign o_result = result_q;
	assign o_valid = stage2_valid;

endmodule

// ==== hdl/emult_core.sv ====
module emult_core import emult_pkg::*; (
	input logic clk,
	input logic reset,
	input logic i_valid,
	input logic i_ready,
	input lane_vec_t i_a,
	input lane_vec_t i_b,
	output lane_vec_t o_c,
	output logic o_valid,
	output logic o_ready
);

	// Downstream ready stalls every register in the pipeline at once.
	logic enable;

	// Capture stage outputs.
	lane_vec_t cap_a;
	lane_vec_t cap_b;
	logic cap_valid;

	// Multiplier outputs, one product per lane and one valid per pair.
	product_t prod [NUM_LANES];
	logic [NUM_PAIRS-1:0] pair_valid;

	// Rounding outputs.
	lane_vec_t result;
	logic [NUM_LANES-1:0] round_valid;

	assign enable = i_ready;

	operand_capture capture_i (
		.clk(clk),
		.reset(reset),
		.i_enable(enable),
		.i_valid(i_valid),
		.i_a(i_a),
		.i_b(i_b),
		.o_a(cap_a),
		.o_b(cap_b),
		.o_valid(cap_valid)
	);

	// Each DSP block takes lanes 2k and 2k+1.
	for (genvar pair = 0; pair < NUM_PAIRS; pair++) begin : g_pair
		dsp_mult_pair mult_i (
			.clk(clk),
			.reset(reset),
			.i_enable(enable),
			.i_valid(cap_valid),
			.i_ax(cap_a[2*pair]),
			.i_ay(cap_b[2*pair]),
			.i_bx(cap_a[2*pair+1]),
			.i_by(cap_b[2*pair+1]),
			.o_res_a(prod[2*pair]),
			.o_res_b(prod[2*pair+1]),
			.o_valid(pair_valid[pair])
		);
	end

	// Both lanes of a pair share that pair's valid.
	for (genvar lane = 0; lane < NUM_LANES; lane++) begin : g_lane
		fixed_round_unit round_i (
			.clk(clk),
			.reset(reset),
			.i_enable(enable),
			.i_valid(pair_valid[lane/2]),
			.i_prod(prod[lane]),
			.o_result(result[lane]),
			.o_valid(round_valid[lane])
		);
	end

	assign o_c = result;

	// All lanes move in lock step, so lane 0 speaks for the whole beat.
	assign o_valid = round_valid[0] & i_ready;
	assign o_ready = i_ready;

endmodule

// ==== tb/emult_tb_model.svh ====
`ifndef EMULT_TB_MODEL_SVH
`define EMULT_TB_MODEL_SVH

// One step of a maximal-length 32-bit Galois LFSR in its right-shift form.
// The caller takes bit 0 of the new state as the random bit.
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	logic [31:0] next;
	next = state >> 1;
	if (state[0]) begin
		next = next ^ 32'h80200003; // Taps of x^32 + x^22 + x^2 + x + 1.
	end
	return next;
endfunction

// Expected result of one lane.
// The exact product has 2*FRAC_BITS fraction bits. Adding half an output LSB
// and flooring gives round-half-up, which is the same as adding the bit just
// below the cut to the truncated value. Only the low DATA_WIDTH bits remain.
function automatic fixed_t lane_reference(input fixed_t a, input fixed_t b);
	longint product;
	longint half_lsb;
	longint rounded;
	product = longint'(a) * longint'(b);
	half_lsb = longint'(1) <<< (FRAC_BITS - 1);
	rounded = (product + half_lsb) >>> FRAC_BITS; // Floor, also for negatives.
	return fixed_t'(rounded[DATA_WIDTH-1:0]);
endfunction

// Expected result vector of a whole beat, lane by lane.
function automatic lane_vec_t beat_reference(input lane_vec_t a, input lane_vec_t b);
	lane_vec_t result;
	result = '0;
	for (int lane = 0; lane < NUM_LANES; lane++) begin
		result[lane] = lane_reference(a[lane], b[lane]);
	end
	return result;
endfunction

`endif

// ==== tb/emult_tb.sv ====
module emult_tb import emult_pkg::*; ();

	logic clk;
	logic reset;
	logic i_valid;
	logic i_ready;
	lane_vec_t i_a;
	lane_vec_t i_b;
	lane_vec_t o_c;
	logic o_valid;
	logic o_ready;

	// Stimulus state that only the driver writes.
	logic [31:0] lfsr_state;
	logic allow_bubbles;
	logic allow_stalls;
	int sent_count; // Beats the driver saw taken on an edge with i_ready high.

	// Checker state that only the checker writes.
	lane_vec_t exp_q[$]; // Expected results in acceptance order.
	int accept_q[$]; // Enabled-edge index at which each beat was accepted.
	lane_vec_t exp_beat;
	int accept_at;
	int enabled_count;
	int delivered_count;
	logic hold_check;
	lane_vec_t held_c;
	logic reset_seen; // Registers are unknown until the first reset edge.

	`include "emult_tb_model.svh"

	emult_core dut_i (
		.clk(clk),
		.reset(reset),
		.i_valid(i_valid),
		.i_ready(i_ready),
		.i_a(i_a),
		.i_b(i_b),
		.o_c(o_c),
		.o_valid(o_valid),
		.o_ready(o_ready)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic compare_lane(input int lane, input fixed_t got, input fixed_t expected,
			input string what);
		if (got !== expected) begin
			abort_run($sformatf("FAILED at time %0t: %s lane %0d is %0d, expected %0d",
				$time, what, lane, got, expected));
		end
	endtask

	task automatic compare_latency(input int got, input int expected);
		if (got !== expected) begin
			abort_run($sformatf("FAILED at time %0t: latency is %0d enabled cycles, expected %0d",
				$time, got, expected));
		end
	endtask

	task automatic compare_count(input int got, input int expected);
		if (got !== expected) begin
			abort_run($sformatf("FAILED at time %0t: %0d results delivered, expected %0d",
				$time, got, expected));
		end
	endtask

	// Takes count random bits with one LFSR step for each.
	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[30:0], lfsr_state[0]};
		end
		return bits;
	endfunction

	function automatic lane_vec_t random_vec();
		lane_vec_t vec;
		vec = '0;
		for (int lane = 0; lane < NUM_LANES; lane++) begin
			vec[lane] = fixed_t'(take_bits(DATA_WIDTH));
		end
		return vec;
	endfunction

	function automatic logic pick_ready();
		if (!allow_stalls) begin
			return 1'b1;
		end
		return take_bits(2) != 0; // Low about one cycle in four.
	endfunction

	// Corner operands start at lane shift and wrap around the lane vector.
	task automatic build_corner(input int shift, output lane_vec_t a, output lane_vec_t b);
		fixed_t max_pos;
		fixed_t max_neg;
		max_pos = fixed_t'(18'h1ffff);
		max_neg = fixed_t'(18'h20000);
		a = random_vec();
		b = random_vec();
		a[(shift + 0) % NUM_LANES] = max_pos; // Wraps the low 18 bits.
		b[(shift + 0) % NUM_LANES] = max_pos;
		a[(shift + 1) % NUM_LANES] = max_neg;
		b[(shift + 1) % NUM_LANES] = max_neg;
		a[(shift + 2) % NUM_LANES] = '0;
		a[(shift + 3) % NUM_LANES] = fixed_t'(-1); // Exact tie at -0.5.
		b[(shift + 3) % NUM_LANES] = fixed_t'(512);
		a[(shift + 4) % NUM_LANES] = fixed_t'(-3); // A tie at -1.5 rounds to -1.
		b[(shift + 4) % NUM_LANES] = fixed_t'(512);
		a[(shift + 5) % NUM_LANES] = fixed_t'(-7); // Bit 9 clear.
		b[(shift + 5) % NUM_LANES] = fixed_t'(100);
		a[(shift + 6) % NUM_LANES] = fixed_t'(-1024); // Exactly -1.0 LSB of output.
		b[(shift + 6) % NUM_LANES] = fixed_t'(1);
		a[(shift + 7) % NUM_LANES] = max_pos;
		b[(shift + 7) % NUM_LANES] = max_neg;
	endtask

	// Holds the beat on the inputs until an edge with i_ready high takes it.
	task automatic send_beat(input lane_vec_t a, input lane_vec_t b);
		int tries;
		logic ready;
		tries = 0;
		ready = pick_ready();
		i_valid <= 1'b1;
		i_a <= a;
		i_b <= b;
		i_ready <= ready;
		@(posedge clk);
		while (!ready) begin
			tries++;
			if (tries > 64) begin
				abort_run("A beat was never accepted because i_ready stayed low.");
			end else begin
				ready = pick_ready();
				i_ready <= ready;
				@(posedge clk);
			end
		end
		sent_count++;
	endtask

	task automatic idle_cycle();
		i_valid <= 1'b0;
		i_a <= random_vec(); // Junk under a bubble must be ignored.
		i_ready <= pick_ready();
		@(posedge clk);
	endtask

	task automatic run_random(input int count);
		lane_vec_t a;
		lane_vec_t b;
		for (int n = 0; n < count; n++) begin
			if (allow_bubbles && take_bits(2) == 0) begin
				repeat (1 + take_bits(2)) begin
					idle_cycle();
				end
			end
			a = random_vec();
			b = random_vec();
			send_beat(a, b);
		end
	endtask

	task automatic drain_pipeline();
		int waited;
		waited = 0;
		i_valid <= 1'b0;
		i_ready <= 1'b1;
		while (exp_q.size() != 0 && waited < 50) begin
			@(negedge clk); // The checker is done with the edge by now.
			waited++;
		end
	endtask

	// Driver.
	initial begin
		lane_vec_t a;
		lane_vec_t b;
		lfsr_state = 32'ha1dd1eb6;
		allow_bubbles = 1'b0;
		allow_stalls = 1'b0;
		sent_count = 0;
		reset = 1'b1;
		i_valid = 1'b0;
		i_ready = 1'b1;
		i_a = '0;
		i_b = '0;
		repeat (16) begin
			@(posedge clk);
			i_ready <= take_bits(1) != 0; // o_ready must follow even in reset.
		end
		reset <= 1'b0;
		i_ready <= 1'b1;
		@(posedge clk);

		// Odd shift puts each corner on the other side of its DSP pair.
		build_corner(0, a, b);
		send_beat(a, b);
		build_corner(9, a, b);
		send_beat(a, b);

		run_random(200);
		allow_bubbles = 1'b1;
		run_random(200);
		allow_stalls = 1'b1;
		run_random(300);

		drain_pipeline();
		if (exp_q.size() != 0) begin
			abort_run($sformatf("Timed out waiting for %0d results to leave the pipeline.",
				exp_q.size()));
		end else begin
			compare_count(delivered_count, sent_count);
			$display("*** PASSED ***");
			$finish;
		end
	end

	// Checker. All values are sampled as they were just before the edge.
	initial begin
		enabled_count = 0;
		delivered_count = 0;
		hold_check = 1'b0;
		held_c = '0;
		reset_seen = 1'b0;
	end

	always @(posedge clk) begin
		if (o_ready !== i_ready) begin
			abort_run($sformatf("FAILED at time %0t: o_ready is %b while i_ready is %b",
				$time, o_ready, i_ready));
		end
		if (reset) begin
			if (reset_seen && o_valid !== 1'b0) begin
				abort_run("o_valid was not low during reset.");
			end
			reset_seen = 1'b1;
			hold_check = 1'b0;
		end else begin
			if (o_valid && !i_ready) begin
				abort_run("o_valid was high while i_ready was low.");
			end
			if (hold_check) begin
				for (int lane = 0; lane < NUM_LANES; lane++) begin
					compare_lane(lane, o_c[lane], held_c[lane], "stalled");
				end
			end
			if (i_ready) begin
				enabled_count++;
			end
			if (i_valid && o_ready) begin
				exp_q.push_back(beat_reference(i_a, i_b));
				accept_q.push_back(enabled_count);
			end
			if (o_valid) begin
				if (exp_q.size() == 0) begin
					abort_run("A result appeared with no accepted beat in flight.");
				end else begin
					exp_beat = exp_q.pop_front();
					accept_at = accept_q.pop_front();
					for (int lane = 0; lane < NUM_LANES; lane++) begin
						compare_lane(lane, o_c[lane], exp_beat[lane], "result");
					end
					compare_latency(enabled_count - accept_at, 5); // Five register stages.
					delivered_count++;
				end
			end
			hold_check = !i_ready;
			held_c = o_c;
		end
	end

endmodule

// ==== build.f ====
+incdir+tb
common/emult_pkg.sv
hdl/operand_capture.sv
mult/dsp_mult_pair.sv
round/fixed_round_unit.sv
hdl/emult_core.sv
tb/emult_tb.sv

// ==== Bender.yml ====
package:
  name: emult

sources:
  # Shared package first, then the RTL in compile order.
  - files:
      - common/emult_pkg.sv
      - hdl/operand_capture.sv
      - mult/dsp_mult_pair.sv
      - round/fixed_round_unit.sv
      - hdl/emult_core.sv

  # Testbench, with its model header on the include path.
  - target: test
    include_dirs:
      - tb
    files:
      - tb/emult_tb.sv
